// File: icache_vectors.txt
# op  addr(hex)  cacheable  expected word(hex)  expected miss
# flush, enable and disable ignore the other columns
fetch    00001020  1  5a5a1020  1
fetch    00001024  1  5a5a1024  0
fetch    0000102c  1  5a5a102c  0
fetch    00001028  1  5a5a1028  0
fetch    00003040  0  5a5a3040  0
fetch    00003040  0  5a5a3040  0
fetch    00003044  1  5a5a3044  1
fetch    00003040  1  5a5a3040  0
flush    00000000  0  00000000  0
fetch    00001020  1  5a5a1020  1
fetch    00003048  1  5a5a3048  1
disable  00000000  0  00000000  0
fetch    00001024  1  5a5a1024  0
fetch    0000304c  1  5a5a304c  0
fetch    12340020  1  486e0020  0
enable   00000000  0  00000000  0
fetch    00001020  1  5a5a1020  1
fetch    00001028  1  5a5a1028  0
fetch    12340024  1  486e0024  1
fetch    abcd1228  1  f1971228  1
fetch    0000772c  1  5a5a772c  1
fetch    00001024  1  5a5a1024  0
fetch    12340028  1  486e0028  0
fetch    abcd1220  1  f1971220  0
fetch    00007720  1  5a5a7720  0
fetch    1234002c  1  486e002c  0

// File: icache.f
icache_pkg.sv
icache_repl.sv
icache_ctrl.sv
icache_arrays.sv
icache_hit_sel.sv
icache_top.sv
tb_icache.sv

// File: tb_icache.sv
////////////////////////////////////////////////////////////
// instruction cache testbench
// clock, reset, vector player, refill memory model
// and response checks against the memory data pattern
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_icache import icache_pkg::*; ();

  localparam int FLUSH_BOUND   = NUM_SETS + 4;
  localparam int READY_TIMEOUT = 40;
  localparam int RSP_TIMEOUT   = 40;
  // memory model phases
  localparam int MEM_IDLE = 0;
  localparam int MEM_ACK  = 1;
  localparam int MEM_RTRN = 2;

  logic       clk_i;
  logic       rst_ni;
  logic       flush_i;
  logic       en_i;
  fetch_req_t fetch_req_i;
  logic       fetch_ready_o;
  fetch_rsp_t fetch_rsp_o;
  logic       miss_o;
  mem_req_t   mem_req_o;
  logic       mem_ack_i;
  mem_rtrn_t  mem_rtrn_i;

  int          errors;
  int          tests;
  int          failed;
  int          req_cnt;
  int          miss_cnt;
  bit          timed_out;
  logic [31:0] rng_q;
  int          mem_phase;
  int          mem_dly;
  mem_req_t    mem_held;
  // line addresses the cache should hold right now
  logic [31:0] resident_q[$];

  icache_top icache_top_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .en_i          (en_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_rsp_o   (fetch_rsp_o),
    .miss_o        (miss_o),
    .mem_req_o     (mem_req_o),
    .mem_ack_i     (mem_ack_i),
    .mem_rtrn_i    (mem_rtrn_i)
  );

  initial begin : clk_gen
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // miss_o lasts one cycle and is counted at the edge that takes the ack
  always @(posedge clk_i) begin
    if (miss_o === 1'b1) begin
      miss_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // every word holds its own byte address xor 5a5a_0000
  function automatic logic [LINE_W-1:0] line_data(input logic [31:0] paddr);
    logic [LINE_W-1:0] line;
    logic [31:0]       base;
    base = {paddr[31:4], 4'h0};
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      line[w*FETCH_W +: FETCH_W] = (base + 32'(4 * w)) ^ 32'h5a5a_0000;
    end
    return line;
  endfunction

  function automatic bit is_resident(input logic [31:0] line_addr);
    for (int i = 0; i < resident_q.size(); i++) begin
      if (resident_q[i] == line_addr) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // fills take the lowest invalid way, so a set fills from way 0 upwards
  function automatic int set_fill_count(input logic [31:0] line_addr);
    int cnt;
    cnt = 0;
    for (int i = 0; i < resident_q.size(); i++) begin
      if (resident_q[i][7:4] == line_addr[7:4]) begin
        cnt++;
      end
    end
    return cnt;
  endfunction

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("mismatch %s %s: expected %h actual %h", name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic wait_ready(input string name, input int limit);
    int waited;
    waited = 0;
    while (!fetch_ready_o && waited < limit) begin
      @(negedge clk_i);
      waited++;
    end
    assert (fetch_ready_o) else begin
      $display("error %s: fetch_ready_o stayed low for %0d cycles", name, limit);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  // steps the memory once per falling edge
  // ack comes after 0..3 cycles and the line 2..5 cycles later
  task automatic step_memory(input string name);
    if (mem_phase == MEM_IDLE && mem_req_o.valid) begin
      mem_held  = mem_req_o;
      req_cnt++;
      rng_q     = xorshift32(rng_q);
      mem_dly   = rng_q % 4;
      mem_phase = MEM_ACK;
    end
    if (mem_phase == MEM_ACK) begin
      assert (mem_req_o === mem_held) else begin
        $display("error %s: mem_req_o changed while mem_ack_i was low", name);
        errors++;
      end
      if (mem_dly == 0) begin
        mem_ack_i = 1'b1;
        rng_q     = xorshift32(rng_q);
        mem_dly   = 2 + rng_q % 4;
        mem_phase = MEM_RTRN;
      end else begin
        mem_dly--;
      end
    end else if (mem_phase == MEM_RTRN) begin
      mem_dly--;
      if (mem_dly == 0) begin
        mem_rtrn_i.valid = 1'b1;
        mem_rtrn_i.data  = line_data(mem_held.paddr);
        mem_phase        = MEM_IDLE;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // operations
  ////////////////////////////////////////////////////////////

  task automatic await_reset_flush(input string name);
    int waited;
    waited = 0;
    while (!fetch_ready_o && waited < FLUSH_BOUND) begin
      check_value(name, "mem_req_o.valid in flush", 32'h0, mem_req_o.valid);
      check_value(name, "fetch_rsp_o.valid in flush", 32'h0, fetch_rsp_o.valid);
      @(negedge clk_i);
      waited++;
    end
    assert (fetch_ready_o) else begin
      $display("error %s: fetch_ready_o did not rise after the reset flush", name);
      errors++;
      timed_out = 1'b1;
    end
    check_value(name, "miss_o pulses", 32'h0, miss_cnt);
  endtask

  task automatic fetch_and_check(input string name, input logic [31:0] addr,
                                 input logic cacheable, input logic [31:0] exp_word,
                                 input logic exp_miss);
    logic [31:0] line_addr;
    logic [31:0] exp_paddr;
    logic        exp_nc;
    logic        exp_mem;
    logic [31:0] rsp_data;
    int          exp_way;
    int          lat;
    int          req_start;
    int          miss_start;
    bit          got_rsp;
    line_addr  = {addr[31:4], 4'h0};
    exp_nc     = !cacheable || !en_i;
    exp_mem    = exp_nc || !is_resident(line_addr);
    exp_paddr  = exp_nc ? {addr[31:2], 2'b00} : line_addr;
    exp_way    = set_fill_count(line_addr);
    req_start  = req_cnt;
    miss_start = miss_cnt;
    @(negedge clk_i);
    wait_ready(name, READY_TIMEOUT);
    if (timed_out) begin
      return;
    end
    // taken on the next rising edge
    fetch_req_i.valid     = 1'b1;
    fetch_req_i.addr.flat = addr;
    fetch_req_i.cacheable = cacheable;
    lat     = 0;
    got_rsp = 1'b0;
    while (!got_rsp && lat < RSP_TIMEOUT) begin
      @(negedge clk_i);
      lat++;
      fetch_req_i.valid = 1'b0;
      mem_ack_i         = 1'b0;
      mem_rtrn_i.valid  = 1'b0;
      if (fetch_rsp_o.valid) begin
        got_rsp  = 1'b1;
        rsp_data = fetch_rsp_o.data;
      end else begin
        check_value(name, "fetch_ready_o while busy", 32'h0, fetch_ready_o);
        step_memory(name);
      end
    end
    assert (got_rsp) else begin
      $display("error %s: no fetch response within %0d cycles", name, RSP_TIMEOUT);
      errors++;
      timed_out = 1'b1;
      return;
    end
    check_value(name, "data", exp_word, rsp_data);
    check_value(name, "miss_o pulses", 32'(exp_miss), miss_cnt - miss_start);
    check_value(name, "memory requests", 32'(exp_mem), req_cnt - req_start);
    if (exp_mem) begin
      check_value(name, "mem_req_o.nc", 32'(exp_nc), mem_held.nc);
      check_value(name, "mem_req_o.paddr", exp_paddr, mem_held.paddr);
      if (!exp_nc) begin
        check_value(name, "mem_req_o.way", 32'(exp_way), mem_held.way);
      end
    end else begin
      check_value(name, "hit latency", 32'd2, lat);
    end
    if (!exp_nc && !is_resident(line_addr)) begin
      resident_q.push_back(line_addr);
    end
  endtask

  task automatic pulse_flush(input string name);
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    check_value(name, "fetch_ready_o in flush", 32'h0, fetch_ready_o);
    wait_ready(name, FLUSH_BOUND);
    resident_q.delete();
  endtask

  // a rising en_i flushes the cache and a repeated enable does nothing
  task automatic raise_enable(input string name);
    logic was_on;
    was_on = en_i;
    @(negedge clk_i);
    en_i = 1'b1;
    @(negedge clk_i);
    if (!was_on) begin
      check_value(name, "fetch_ready_o in flush", 32'h0, fetch_ready_o);
      wait_ready(name, FLUSH_BOUND);
      resident_q.delete();
    end else begin
      check_value(name, "fetch_ready_o", 32'h1, fetch_ready_o);
    end
  endtask

  task automatic drop_enable(input string name);
    @(negedge clk_i);
    en_i = 1'b0;
    @(negedge clk_i);
    check_value(name, "fetch_ready_o", 32'h1, fetch_ready_o);
  endtask

  task automatic report_test(input string name, input int err_start);
    tests++;
    if (errors > err_start) begin
      failed++;
      $display("%-12s failed", name);
    end else begin
      $display("%-12s ok", name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // vector player
  ////////////////////////////////////////////////////////////

  initial begin : main
    string       text;
    string       op;
    string       name;
    int          fd;
    int          n;
    int          vec_idx;
    int          err_start;
    logic [31:0] addr;
    logic [31:0] cacheable;
    logic [31:0] exp_word;
    logic [31:0] exp_miss;
    errors      = 0;
    tests       = 0;
    failed      = 0;
    req_cnt     = 0;
    miss_cnt    = 0;
    timed_out   = 1'b0;
    rng_q       = 32'h256a;
    mem_phase   = MEM_IDLE;
    mem_dly     = 0;
    vec_idx     = 0;
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    en_i        = 1'b1;
    fetch_req_i = '0;
    mem_ack_i   = 1'b0;
    mem_rtrn_i  = '0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    err_start = errors;
    await_reset_flush("reset_flush");
    report_test("reset_flush", err_start);

    fd = $fopen("icache_vectors.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open icache_vectors.txt");
      errors++;
    end else begin
      while (!timed_out && $fgets(text, fd) != 0) begin
        // skip column notes and blank lines
        if (text.len() < 2 || text.substr(0, 0) == "#") begin
          continue;
        end
        n = $sscanf(text, "%s %h %h %h %h", op, addr, cacheable, exp_word, exp_miss);
        if (n != 5) begin
          $display("error: malformed vector line: %s", text);
          errors++;
          continue;
        end
        vec_idx++;
        name      = $sformatf("%s_%0d", op, vec_idx);
        err_start = errors;
        if (op == "fetch") begin
          fetch_and_check(name, addr, cacheable[0], exp_word, exp_miss[0]);
        end else if (op == "flush") begin
          pulse_flush(name);
        end else if (op == "enable") begin
          raise_enable(name);
        end else if (op == "disable") begin
          drop_enable(name);
        end else begin
          $display("error %s: unknown operation in vector file", name);
          errors++;
        end
        report_test(name, err_start);
      end
      $fclose(fd);
    end

    $display("tests run %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: icache_top.sv
////////////////////////////////////////////////////////////
// instruction cache top level
// controller, storage arrays and hit select
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  input  logic       en_i,
  input  fetch_req_t fetch_req_i,
  output logic       fetch_ready_o,
  output fetch_rsp_t fetch_rsp_o,
  output logic       miss_o,
  output mem_req_t   mem_req_o,
  input  logic       mem_ack_i,
  input  mem_rtrn_t  mem_rtrn_i
);

  // controller to arrays
  logic                 rd_en;
  logic                 fill_en;
  logic                 clr_en;
  logic [SET_IDX_W-1:0] set_idx;
  logic [WAY_IDX_W-1:0] fill_way;
  // controller to hit select
  fetch_addr_u          req_addr;
  logic                 rsp_hit_en;
  logic                 rsp_fill_en;
  logic                 hit;
  // array read data
  tag_arr_t             tags;
  way_vec_t             valid_bits;
  line_arr_t            lines;

  icache_ctrl icache_ctrl_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .en_i          (en_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_ready_o (fetch_ready_o),
    .mem_req_o     (mem_req_o),
    .mem_ack_i     (mem_ack_i),
    .mem_rtrn_i    (mem_rtrn_i),
    .miss_o        (miss_o),
    .hit_i         (hit),
    .valid_bits_i  (valid_bits),
    .rd_en_o       (rd_en),
    .fill_en_o     (fill_en),
    .clr_en_o      (clr_en),
    .set_idx_o     (set_idx),
    .fill_way_o    (fill_way),
    .req_addr_o    (req_addr),
    .rsp_hit_en_o  (rsp_hit_en),
    .rsp_fill_en_o (rsp_fill_en)
  );

  // refill writes the latched tag with the returning line
  icache_arrays icache_arrays_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_en_i      (rd_en),
    .fill_en_i    (fill_en),
    .clr_en_i     (clr_en),
    .set_idx_i    (set_idx),
    .fill_way_i   (fill_way),
    .fill_tag_i   (req_addr.fields.tag),
    .fill_line_i  (mem_rtrn_i.data),
    .tags_o       (tags),
    .valid_bits_o (valid_bits),
    .lines_o      (lines)
  );

  icache_hit_sel icache_hit_sel_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_addr_i    (req_addr),
    .tags_i        (tags),
    .valid_bits_i  (valid_bits),
    .lines_i       (lines),
    .rtrn_line_i   (mem_rtrn_i.data),
    .rsp_hit_en_i  (rsp_hit_en),
    .rsp_fill_en_i (rsp_fill_en),
    .hit_o         (hit),
    .fetch_rsp_o   (fetch_rsp_o)
  );

endmodule

`default_nettype wire

// File: icache_hit_sel.sv
////////////////////////////////////////////////////////////
// tag compare and hit way encode
// fetch word select from hit line or refill line
// registered fetch response
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_hit_sel import icache_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  fetch_addr_u       req_addr_i,
  input  tag_arr_t          tags_i,
  input  way_vec_t          valid_bits_i,
  input  line_arr_t         lines_i,
  input  logic [LINE_W-1:0] rtrn_line_i,
  input  logic              rsp_hit_en_i,
  input  logic              rsp_fill_en_i,
  output logic              hit_o,
  output fetch_rsp_t        fetch_rsp_o
);

  way_vec_t                     match;
  logic [WAY_IDX_W-1:0]         hit_way;
  logic [$clog2(LINE_W)-1:0]    bit_ofs;
  logic [FETCH_W-1:0]           hit_word;
  logic [FETCH_W-1:0]           fill_word;
  logic                         rsp_vld_q;
  logic [FETCH_W-1:0]           rsp_data_q;

  // per-way compare, lowest matching way wins
  always_comb begin : p_cmp
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      match[w] = valid_bits_i[w] && (tags_i[w] == req_addr_i.fields.tag);
    end
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (match[w]) begin
        hit_way = WAY_IDX_W'(w);
      end
    end
  end

  assign hit_o = |match;

  // word select is the same for hit and refill
  assign bit_ofs   = {req_addr_i.fields.word_sel, {$clog2(FETCH_W){1'b0}}};
  assign hit_word  = lines_i[hit_way][bit_ofs +: FETCH_W];
  assign fill_word = rtrn_line_i[bit_ofs +: FETCH_W];

  ////////////////////////////////////////////////////////////
  // response register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rsp_vld
    if (!rst_ni) begin
      rsp_vld_q <= 1'b0;
    end else begin
      rsp_vld_q <= rsp_hit_en_i | rsp_fill_en_i;
    end
  end

  always_ff @(posedge clk_i) begin : p_rsp_data
    if (rsp_hit_en_i) begin
      rsp_data_q <= hit_word;
    end else if (rsp_fill_en_i) begin
      rsp_data_q <= fill_word;
    end
  end

  assign fetch_rsp_o.valid = rsp_vld_q;
  assign fetch_rsp_o.data  = rsp_data_q;

endmodule

`default_nettype wire

// File: icache_arrays.sv
////////////////////////////////////////////////////////////
// tag, valid and line storage, all ways per set
// synchronous read with registered outputs
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_arrays import icache_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rd_en_i,
  input  logic                 fill_en_i,
  input  logic                 clr_en_i,
  input  logic [SET_IDX_W-1:0] set_idx_i,
  input  logic [WAY_IDX_W-1:0] fill_way_i,
  input  logic [TAG_W-1:0]     fill_tag_i,
  input  logic [LINE_W-1:0]    fill_line_i,
  output tag_arr_t             tags_o,
  output way_vec_t             valid_bits_o,
  output line_arr_t            lines_o
);

  way_vec_t  valid_q [NUM_SETS];
  tag_arr_t  tag_mem [NUM_SETS];
  line_arr_t line_mem[NUM_SETS];

  ////////////////////////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////////////////////////

  // clear takes the whole set, fill marks one way
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
      end
      valid_bits_o <= '0;
    end else begin
      if (clr_en_i) begin
        valid_q[set_idx_i] <= '0;
      end else if (fill_en_i) begin
        valid_q[set_idx_i][fill_way_i] <= 1'b1;
      end
      if (rd_en_i) begin
        valid_bits_o <= valid_q[set_idx_i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // tags and lines
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin : p_store
    if (fill_en_i) begin
      tag_mem[set_idx_i][fill_way_i]  <= fill_tag_i;
      line_mem[set_idx_i][fill_way_i] <= fill_line_i;
    end
    // read ports hold their value between lookups
    if (rd_en_i) begin
      tags_o  <= tag_mem[set_idx_i];
      lines_o <= line_mem[set_idx_i];
    end
  end

endmodule

`default_nettype wire

// File: icache_ctrl.sv
////////////////////////////////////////////////////////////
// instruction cache controller
// flush / idle / read / miss fsm, request latch,
// flush counter and refill request to memory
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 en_i,
  input  fetch_req_t           fetch_req_i,
  output logic                 fetch_ready_o,
  output mem_req_t             mem_req_o,
  input  logic                 mem_ack_i,
  input  mem_rtrn_t            mem_rtrn_i,
  output logic                 miss_o,
  input  logic                 hit_i,
  input  way_vec_t             valid_bits_i,
  output logic                 rd_en_o,
  output logic                 fill_en_o,
  output logic                 clr_en_o,
  output logic [SET_IDX_W-1:0] set_idx_o,
  output logic [WAY_IDX_W-1:0] fill_way_o,
  output fetch_addr_u          req_addr_o,
  output logic                 rsp_hit_en_o,
  output logic                 rsp_fill_en_o
);

  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } state_e;

  state_e               state_d, state_q;
  logic                 cache_en_d, cache_en_q;
  logic                 flush_d, flush_q;
  logic [SET_IDX_W-1:0] flush_cnt_d, flush_cnt_q;
  // access goes to memory and is never allocated
  logic                 nc_d, nc_q;
  logic                 mem_vld_d, mem_vld_q;
  logic                 accept;
  logic                 capture;
  fetch_addr_u          req_addr_q;
  logic [WAY_IDX_W-1:0] victim_way, victim_q;
  logic                 full_q;

  ////////////////////////////////////////////////////////////
  // main fsm
  ////////////////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d       = state_q;
    // disabling acts at once, enabling goes through a flush
    cache_en_d    = cache_en_q & en_i;
    flush_d       = flush_q | flush_i;
    flush_cnt_d   = flush_cnt_q;
    nc_d          = nc_q;
    mem_vld_d     = mem_vld_q;
    accept        = 1'b0;
    capture       = 1'b0;
    fetch_ready_o = 1'b0;
    rd_en_o       = 1'b0;
    fill_en_o     = 1'b0;
    clr_en_o      = 1'b0;
    rsp_hit_en_o  = 1'b0;
    rsp_fill_en_o = 1'b0;
    miss_o        = 1'b0;
    set_idx_o     = req_addr_q.fields.set_idx;

    unique case (state_q)
      // one set cleared per cycle
      FLUSH: begin
        clr_en_o    = 1'b1;
        set_idx_o   = flush_cnt_q;
        flush_cnt_d = flush_cnt_q + 1'b1;
        if (flush_cnt_q == SET_IDX_W'(NUM_SETS - 1)) begin
          state_d    = IDLE;
          flush_d    = flush_i;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else if (!mem_rtrn_i.valid) begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i.valid) begin
            accept    = 1'b1;
            rd_en_o   = 1'b1;
            set_idx_o = fetch_req_i.addr.fields.set_idx;
            nc_d      = !fetch_req_i.cacheable || !cache_en_q;
            state_d   = READ;
          end
        end
      end
      // tag compare, victim way captured here
      READ: begin
        capture = 1'b1;
        if (hit_i && !nc_q && cache_en_q) begin
          rsp_hit_en_o = 1'b1;
          state_d      = IDLE;
        end else begin
          nc_d      = nc_q || !cache_en_q;
          mem_vld_d = 1'b1;
          state_d   = MISS;
        end
      end
      // hold the request until acked, then wait for the line
      MISS: begin
        if (mem_vld_q && mem_ack_i) begin
          mem_vld_d = 1'b0;
          miss_o    = !nc_q && cache_en_q;
        end
        if (mem_rtrn_i.valid) begin
          rsp_fill_en_o = 1'b1;
          fill_en_o     = !nc_q && cache_en_q;
          state_d       = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      nc_q        <= 1'b0;
      mem_vld_q   <= 1'b0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
      nc_q        <= nc_d;
      mem_vld_q   <= mem_vld_d;
    end
  end

  // request address and victim data
  always_ff @(posedge clk_i) begin : p_payload
    if (accept) begin
      req_addr_q <= fetch_req_i.addr;
    end
    if (capture) begin
      victim_q <= victim_way;
      full_q   <= &valid_bits_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // replacement and refill request
  ////////////////////////////////////////////////////////////

  icache_repl icache_repl_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_bits_i (valid_bits_i),
    .advance_i    (fill_en_o & full_q),
    .victim_way_o (victim_way)
  );

  assign mem_req_o.valid = mem_vld_q;
  // word address for nc, line address otherwise
  assign mem_req_o.paddr = nc_q ?
      {req_addr_q.flat[ADDR_W-1:OFFSET_W-WORD_SEL_W], {(OFFSET_W - WORD_SEL_W){1'b0}}} :
      {req_addr_q.flat[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign mem_req_o.nc    = nc_q;
  assign mem_req_o.way   = victim_q;

  assign fill_way_o = victim_q;
  assign req_addr_o = req_addr_q;

endmodule

`default_nettype wire

// File: icache_repl.sv
////////////////////////////////////////////////////////////
// victim way choice for line allocation
// lowest invalid way, else lfsr pick on a full set
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module icache_repl import icache_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  way_vec_t             valid_bits_i,
  input  logic                 advance_i,
  output logic [WAY_IDX_W-1:0] victim_way_o
);

  logic [LFSR_W-1:0]    lfsr_q;
  logic [WAY_IDX_W-1:0] inv_way;
  logic                 all_valid;

  // scan downwards so the lowest invalid way wins
  always_comb begin : p_inv_find
    inv_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_bits_i[w]) begin
        inv_way = WAY_IDX_W'(w);
      end
    end
  end

  assign all_valid = &valid_bits_i;

  // x^8 + x^6 + x^5 + x^4 + 1, steps only on allocation into a full set
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lfsr
    if (!rst_ni) begin
      lfsr_q <= LFSR_SEED;
    end else if (advance_i) begin
      lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

  assign victim_way_o = all_valid ? lfsr_q[WAY_IDX_W-1:0] : inv_way;

endmodule

`default_nettype wire

// File: icache_pkg.sv
////////////////////////////////////////////////////////////
// instruction cache shared definitions
// cache geometry, fetch address views and port structs
////////////////////////////////////////////////////////////

`default_nettype none

package icache_pkg;

  ////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W         = 32;
  localparam int FETCH_W        = 32;
  localparam int LINE_W         = 128;
  localparam int WORDS_PER_LINE = LINE_W / FETCH_W;
  localparam int WORD_SEL_W     = 2;
  localparam int OFFSET_W       = 4;
  localparam int NUM_SETS       = 16;
  localparam int SET_IDX_W      = 4;
  localparam int NUM_WAYS       = 4;
  localparam int WAY_IDX_W      = 2;
  localparam int TAG_W          = ADDR_W - SET_IDX_W - OFFSET_W;

  // replacement lfsr
  localparam int               LFSR_W    = 8;
  localparam logic [LFSR_W-1:0] LFSR_SEED = 8'ha5;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  // one bit per way
  typedef logic [NUM_WAYS-1:0] way_vec_t;

  // per-way tag and line words as read from a set
  typedef logic [NUM_WAYS-1:0][TAG_W-1:0]  tag_arr_t;
  typedef logic [NUM_WAYS-1:0][LINE_W-1:0] line_arr_t;

  // address split as the arrays see it
  typedef struct packed {
    logic [TAG_W-1:0]               tag;
    logic [SET_IDX_W-1:0]           set_idx;
    logic [WORD_SEL_W-1:0]          word_sel;
    logic [OFFSET_W-WORD_SEL_W-1:0] byte_sel;
  } fetch_addr_fields_t;

  // flat view for refill addresses, field view for lookup
  typedef union packed {
    logic [ADDR_W-1:0]  flat;
    fetch_addr_fields_t fields;
  } fetch_addr_u;

  typedef struct packed {
    logic        valid;
    fetch_addr_u addr;
    logic        cacheable;
  } fetch_req_t;

  typedef struct packed {
    logic               valid;
    logic [FETCH_W-1:0] data;
  } fetch_rsp_t;

  // paddr is line aligned, or word aligned when nc is set
  typedef struct packed {
    logic                 valid;
    logic [ADDR_W-1:0]    paddr;
    logic                 nc;
    logic [WAY_IDX_W-1:0] way;
  } mem_req_t;

  typedef struct packed {
    logic              valid;
    logic [LINE_W-1:0] data;
  } mem_rtrn_t;

endpackage

`default_nettype wire
